//--- Bender.yml
package:
  name: rv_core

sources:
  - include_dirs:
      - .
    files:
      - rv_core_pkg.sv
      - control_unit.sv
      - alu.sv
      - reg_file.sv
      - imm_gen.sv
      - pc_unit.sv
      - mem_port.sv
      - rv_core.sv
  - target: test
    include_dirs:
      - .
    files:
      - tb_clock_gen.sv
      - rv_core_tb.sv

//--- alu.sv
`timescale 1ns/1ps
`default_nettype none

`include "rv_core_settings.svh"

module alu
  import rv_core_pkg::*;
(
  input  word_t   a,
  input  word_t   b,
  input  alu_op_t alu_op,
  input  logic    alu_signed,
  input  logic    alu_invert,
  output word_t   result,
  output logic    cmp
);

  logic [4:0] shamt;
  logic       less;
  word_t      sra;

  assign shamt = b[4:0];
  assign less  = alu_signed ? ($signed(a) < $signed(b)) : (a < b);
  assign sra   = $signed(a) >>> shamt;

  always_comb begin
    case (alu_op)
      `ALU_ADD: result = a + b;
      `ALU_SUB: result = a - b;
      `ALU_SLL: result = a << shamt;
      `ALU_SLT: result = {{(`XLEN-1){1'b0}}, less};
      `ALU_XOR: result = a ^ b;
      `ALU_SRL: result = alu_signed ? sra : (a >> shamt);
      `ALU_OR:  result = a | b;
      `ALU_AND: result = a & b;
      `ALU_EQ:  result = {{(`XLEN-1){1'b0}}, a == b};
      default:  result = '0;
    endcase
  end

  assign cmp = result[0] ^ alu_invert; // branch condition.

endmodule

`default_nettype wire

//--- control_unit.sv
`timescale 1ns/1ps
`default_nettype none

`include "rv_core_settings.svh"

module control_unit
  import rv_core_pkg::*;
(
  input  logic      clk,
  input  logic      rst,
  input  opcode_t   opcode,
  input  funct3_t   funct3,
  input  funct7_t   funct7,
  input  logic      stall,
  output logic      fetch,
  output logic      load_ir,
  output logic      pc_en,
  output logic      writeback,
  output logic      data_access,
  output logic      data_we,
  output alu_op_t   alu_op,
  output logic      alu_signed,
  output logic      alu_invert,
  output logic      sel_a,
  output logic      sel_b,
  output dest_sel_t dest_sel,
  output logic      pc_alu,
  output logic      is_branch,
  output logic      trap
);

  localparam logic [1:0] OPSRC_ADD   = 2'd0; // address and jump sums.
  localparam logic [1:0] OPSRC_ARITH = 2'd1; // from funct3 and funct7.
  localparam logic [1:0] OPSRC_CMP   = 2'd2; // branch compare.

  cu_state_t  state;
  logic [1:0] op_src;
  logic       illegal;
  logic       is_mem;

  always_ff @(posedge clk, negedge rst) begin
    if (!rst) begin
      state <= CU_ADDR_OUT;
      trap  <= 1'b0;
    end else if (!stall && !trap) begin
      case (state)
        CU_ADDR_OUT: state <= CU_LOAD_IR;
        CU_LOAD_IR:  state <= CU_EXEC;
        CU_EXEC: begin
          if (illegal) begin
            trap <= 1'b1; // core parks in exec until reset.
          end else begin
            state <= CU_WRITEBACK;
          end
        end
        CU_WRITEBACK: state <= CU_ADDR_OUT;
        default:      state <= CU_ADDR_OUT;
      endcase
    end
  end

  assign is_mem      = (opcode == `OP_LOAD) || (opcode == `OP_STORE);
  assign data_we     = opcode == `OP_STORE;
  assign is_branch   = opcode == `OP_BRANCH;

  assign fetch       = (state == CU_ADDR_OUT) && !trap;
  assign load_ir     = state == CU_LOAD_IR;
  assign pc_en       = (state == CU_EXEC) && !illegal && !trap;
  assign writeback   = (state == CU_WRITEBACK) && !stall; // last writeback cycle.
  assign data_access = (state == CU_WRITEBACK) && is_mem;

  always_comb begin
    sel_a    = `SEL_A_REG;
    sel_b    = `SEL_B_REG;
    dest_sel = `DEST_NONE;
    pc_alu   = `PC_NEXT;
    op_src   = OPSRC_ADD;
    illegal  = 1'b0;
    case (opcode)
      `OP_ALU: begin
        op_src   = OPSRC_ARITH;
        dest_sel = `DEST_ALU;
      end
      `OP_ALUI: begin
        sel_b    = `SEL_B_IMM;
        op_src   = OPSRC_ARITH;
        dest_sel = `DEST_ALU;
      end
      `OP_LOAD: begin
        sel_b    = `SEL_B_IMM;
        dest_sel = `DEST_MEM;
        illegal  = funct3 != `F3_WORD; // words only.
      end
      `OP_STORE: begin
        sel_b   = `SEL_B_IMM;
        illegal = funct3 != `F3_WORD;
      end
      `OP_BRANCH: begin
        op_src  = OPSRC_CMP;
        illegal = funct3[2:1] == 2'b01; // no branch uses 010 or 011.
      end
      `OP_JAL: begin
        sel_a    = `SEL_A_PC;
        sel_b    = `SEL_B_IMM;
        dest_sel = `DEST_PC;
        pc_alu   = `PC_ALU;
      end
      `OP_JALR: begin
        sel_b    = `SEL_B_IMM;
        dest_sel = `DEST_PC;
        pc_alu   = `PC_ALU;
      end
      `OP_LUI: begin
        sel_b    = `SEL_B_IMM; // rs1 reads x0 for lui.
        dest_sel = `DEST_ALU;
      end
      `OP_AUIPC: begin
        sel_a    = `SEL_A_PC;
        sel_b    = `SEL_B_IMM;
        dest_sel = `DEST_ALU;
      end
      default: illegal = 1'b1;
    endcase
  end

  always_comb begin
    alu_op     = `ALU_ADD;
    alu_signed = 1'b0;
    alu_invert = 1'b0;
    case (op_src)
      OPSRC_ARITH: begin
        case (funct3)
          `F3_ADD_SUB: begin
            if (opcode == `OP_ALU && funct7 == `F7_ALT) begin
              alu_op = `ALU_SUB;
            end
          end
          `F3_SLL: alu_op = `ALU_SLL;
          `F3_SLT: begin
            alu_op     = `ALU_SLT;
            alu_signed = 1'b1;
          end
          `F3_SLTU: alu_op = `ALU_SLT;
          `F3_XOR:  alu_op = `ALU_XOR;
          `F3_SRL_SRA: begin
            alu_op     = `ALU_SRL;
            alu_signed = funct7 == `F7_ALT; // sra and srai.
          end
          `F3_OR:  alu_op = `ALU_OR;
          `F3_AND: alu_op = `ALU_AND;
        endcase
      end
      OPSRC_CMP: begin
        // funct3 bit 2 picks less-than, bit 1 unsigned, bit 0 negate
        alu_op     = funct3[2] ? `ALU_SLT : `ALU_EQ;
        alu_signed = !funct3[1];
        alu_invert = funct3[0];
      end
      default: alu_op = `ALU_ADD;
    endcase
  end

endmodule

`default_nettype wire

//--- imm_gen.sv
`timescale 1ns/1ps
`default_nettype none

`include "rv_core_settings.svh"

module imm_gen
  import rv_core_pkg::*;
(
  input  word_t instr,
  output word_t imm
);

  opcode_t opcode;

  assign opcode = instr[6:0];

  always_comb begin
    case (opcode)
      `OP_STORE: begin
        imm = {{20{instr[31]}}, instr[31:25], instr[11:7]};
      end
      `OP_BRANCH: begin
        imm = {{19{instr[31]}}, instr[31], instr[7], instr[30:25], instr[11:8], 1'b0};
      end
      `OP_LUI, `OP_AUIPC: begin
        imm = {instr[31:12], 12'b0};
      end
      `OP_JAL: begin
        imm = {{11{instr[31]}}, instr[31], instr[19:12], instr[20], instr[30:21], 1'b0};
      end
      default: begin
        imm = {{20{instr[31]}}, instr[31:20]}; // I format.
      end
    endcase
  end

endmodule

`default_nettype wire

//--- mem_port.sv
`timescale 1ns/1ps
`default_nettype none

module mem_port
  import rv_core_pkg::*;
(
  input  logic  clk,
  input  logic  rst,
  input  logic  fetch,
  input  logic  data_access,
  input  logic  data_we,
  input  word_t pc,
  input  word_t addr,
  input  word_t wdata,
  output logic  busy,
  output word_t rdata,
  output logic  mem_req,
  output logic  mem_we,
  output word_t mem_addr,
  output word_t mem_wdata,
  input  logic  mem_ack,
  input  word_t mem_rdata
);

  typedef enum logic [1:0] {
    MP_IDLE,
    MP_REQUEST, // req high, waiting for ack.
    MP_RELEASE  // req dropped, waiting for ack low.
  } mp_state_t;

  mp_state_t state;
  logic      fetch_q;
  logic      data_q;
  logic      start_fetch;
  logic      start_data;

  assign start_fetch = fetch && !fetch_q;
  assign start_data  = data_access && !data_q;
  assign busy        = start_fetch || start_data || (state != MP_IDLE);
  assign mem_req     = state == MP_REQUEST;

  always_ff @(posedge clk, negedge rst) begin
    if (!rst) begin
      state   <= MP_IDLE;
      fetch_q <= 1'b0;
      data_q  <= 1'b0;
      mem_we  <= 1'b0;
    end else begin
      fetch_q <= fetch;
      data_q  <= data_access;
      case (state)
        MP_IDLE: begin
          if (start_fetch || start_data) begin
            state  <= MP_REQUEST;
            mem_we <= start_data && data_we;
          end
        end
        MP_REQUEST: if (mem_ack) state <= MP_RELEASE;
        MP_RELEASE: if (!mem_ack) state <= MP_IDLE;
        default:    state <= MP_IDLE;
      endcase
    end
  end

  always_ff @(posedge clk) begin
    if (state == MP_IDLE && (start_fetch || start_data)) begin
      mem_addr  <= start_fetch ? pc : addr;
      mem_wdata <= wdata;
    end
    if (state == MP_REQUEST && mem_ack) begin
      rdata <= mem_rdata; // held for ir or load write-back.
    end
  end

endmodule

`default_nettype wire

//--- pc_unit.sv
`timescale 1ns/1ps
`default_nettype none

`include "rv_core_settings.svh"

module pc_unit
  import rv_core_pkg::*;
(
  input  logic  clk,
  input  logic  rst,
  input  logic  pc_en,
  input  logic  pc_alu,
  input  logic  is_branch,
  input  logic  branch_taken,
  input  word_t imm,
  input  word_t alu_result,
  output word_t pc,
  output word_t pc_plus4
);

  word_t branch_target;
  word_t next_pc;

  assign pc_plus4      = pc + word_t'(4);
  assign branch_target = pc + imm;

  always_comb begin
    if (pc_alu == `PC_ALU) begin
      next_pc = {alu_result[`XLEN-1:1], 1'b0}; // jal and jalr.
    end else if (is_branch && branch_taken) begin
      next_pc = branch_target;
    end else begin
      next_pc = pc_plus4;
    end
  end

  always_ff @(posedge clk, negedge rst) begin
    if (!rst) begin
      pc <= `RESET_PC;
    end else if (pc_en) begin
      pc <= next_pc;
    end
  end

endmodule

`default_nettype wire

//--- reg_file.sv
`timescale 1ns/1ps
`default_nettype none

`include "rv_core_settings.svh"

module reg_file
  import rv_core_pkg::*;
(
  input  logic      clk,
  input  logic      rst,
  input  reg_addr_t rs1,
  input  reg_addr_t rs2,
  input  reg_addr_t rd,
  input  logic      we,
  input  word_t     wdata,
  output word_t     rdata1,
  output word_t     rdata2
);

  word_t regs [`REG_COUNT];

  always_ff @(posedge clk, negedge rst) begin
    if (!rst) begin
      for (int i = 0; i < `REG_COUNT; i++) begin
        regs[i] <= '0;
      end
    end else if (we && rd != '0) begin
      regs[rd] <= wdata;
    end
  end

  assign rdata1 = (rs1 == '0) ? '0 : regs[rs1];
  assign rdata2 = (rs2 == '0) ? '0 : regs[rs2];

endmodule

`default_nettype wire

//--- rv_core.f
+incdir+.
rv_core_pkg.sv
control_unit.sv
alu.sv
reg_file.sv
imm_gen.sv
pc_unit.sv
mem_port.sv
rv_core.sv
tb_clock_gen.sv
rv_core_tb.sv

//--- rv_core.sv
`timescale 1ns/1ps
`default_nettype none

`include "rv_core_settings.svh"

module rv_core
  import rv_core_pkg::*;
(
  input  logic  clk,
  input  logic  rst,
  output logic  mem_req,
  output logic  mem_we,
  output word_t mem_addr,
  output word_t mem_wdata,
  input  logic  mem_ack,
  input  word_t mem_rdata,
  output logic  trap
);

  word_t     ir;
  word_t     exec_q;
  word_t     imm;
  word_t     pc;
  word_t     pc_plus4;
  word_t     rdata1;
  word_t     rdata2;
  word_t     op_a;
  word_t     op_b;
  word_t     alu_result;
  word_t     mem_data;
  word_t     wb_data;
  reg_addr_t rs1;
  alu_op_t   alu_op;
  dest_sel_t dest_sel;
  logic      fetch;
  logic      load_ir;
  logic      pc_en;
  logic      writeback;
  logic      data_access;
  logic      data_we;
  logic      busy;
  logic      alu_signed;
  logic      alu_invert;
  logic      sel_a;
  logic      sel_b;
  logic      pc_alu;
  logic      is_branch;
  logic      cmp;
  logic      rf_we;

  always_ff @(posedge clk, negedge rst) begin
    if (!rst) begin
      ir <= '0;
    end else if (load_ir) begin
      ir <= mem_data;
    end
  end

  // the pc moves at the end of exec, so the result and link are held here
  always_ff @(posedge clk) begin
    if (pc_en) begin
      exec_q <= (dest_sel == `DEST_PC) ? pc_plus4 : alu_result;
    end
  end

  assign rs1     = (ir[6:0] == `OP_LUI) ? '0 : ir[19:15]; // lui adds to zero.
  assign op_a    = (sel_a == `SEL_A_PC) ? pc : rdata1;
  assign op_b    = (sel_b == `SEL_B_IMM) ? imm : rdata2;
  assign wb_data = (dest_sel == `DEST_MEM) ? mem_data : exec_q;
  assign rf_we   = writeback && (dest_sel != `DEST_NONE);

  control_unit u_control_unit (
    .clk         (clk),
    .rst         (rst),
    .opcode      (ir[6:0]),
    .funct3      (ir[14:12]),
    .funct7      (ir[31:25]),
    .stall       (busy),
    .fetch       (fetch),
    .load_ir     (load_ir),
    .pc_en       (pc_en),
    .writeback   (writeback),
    .data_access (data_access),
    .data_we     (data_we),
    .alu_op      (alu_op),
    .alu_signed  (alu_signed),
    .alu_invert  (alu_invert),
    .sel_a       (sel_a),
    .sel_b       (sel_b),
    .dest_sel    (dest_sel),
    .pc_alu      (pc_alu),
    .is_branch   (is_branch),
    .trap        (trap)
  );

  alu u_alu (
    .a          (op_a),
    .b          (op_b),
    .alu_op     (alu_op),
    .alu_signed (alu_signed),
    .alu_invert (alu_invert),
    .result     (alu_result),
    .cmp        (cmp)
  );

  reg_file u_reg_file (
    .clk    (clk),
    .rst    (rst),
    .rs1    (rs1),
    .rs2    (ir[24:20]),
    .rd     (ir[11:7]),
    .we     (rf_we),
    .wdata  (wb_data),
    .rdata1 (rdata1),
    .rdata2 (rdata2)
  );

  imm_gen u_imm_gen (
    .instr (ir),
    .imm   (imm)
  );

  pc_unit u_pc_unit (
    .clk          (clk),
    .rst          (rst),
    .pc_en        (pc_en),
    .pc_alu       (pc_alu),
    .is_branch    (is_branch),
    .branch_taken (cmp),
    .imm          (imm),
    .alu_result   (alu_result),
    .pc           (pc),
    .pc_plus4     (pc_plus4)
  );

  mem_port u_mem_port (
    .clk         (clk),
    .rst         (rst),
    .fetch       (fetch),
    .data_access (data_access),
    .data_we     (data_we),
    .pc          (pc),
    .addr        (exec_q),
    .wdata       (rdata2),
    .busy        (busy),
    .rdata       (mem_data),
    .mem_req     (mem_req),
    .mem_we      (mem_we),
    .mem_addr    (mem_addr),
    .mem_wdata   (mem_wdata),
    .mem_ack     (mem_ack),
    .mem_rdata   (mem_rdata)
  );

endmodule

`default_nettype wire

//--- rv_core_pkg.sv
`default_nettype none

`include "rv_core_settings.svh"

package rv_core_pkg;

  typedef logic [`XLEN-1:0] word_t;     // data word and byte address.
  typedef logic [4:0]       reg_addr_t; // x0 to x31.

  typedef logic [6:0] opcode_t;
  typedef logic [2:0] funct3_t;
  typedef logic [6:0] funct7_t;

  typedef logic [3:0] alu_op_t;   // one of the ALU_* codes.
  typedef logic [1:0] dest_sel_t; // one of the DEST_* codes.

  // one instruction passes through all four phases in order
  typedef enum logic [1:0] {
    CU_ADDR_OUT,
    CU_LOAD_IR,
    CU_EXEC,
    CU_WRITEBACK
  } cu_state_t;

endpackage

`default_nettype wire

//--- rv_core_settings.svh
`ifndef RV_CORE_SETTINGS_SVH
`define RV_CORE_SETTINGS_SVH

`define XLEN      32
`define REG_COUNT 32
`define RESET_PC  32'h0000_0000

`define OP_ALU    7'b0110011
`define OP_ALUI   7'b0010011
`define OP_LOAD   7'b0000011
`define OP_STORE  7'b0100011
`define OP_BRANCH 7'b1100011
`define OP_JAL    7'b1101111
`define OP_JALR   7'b1100111
`define OP_LUI    7'b0110111
`define OP_AUIPC  7'b0010111

`define F3_ADD_SUB 3'b000
`define F3_SLL     3'b001
`define F3_SLT     3'b010
`define F3_SLTU    3'b011
`define F3_XOR     3'b100
`define F3_SRL_SRA 3'b101
`define F3_OR      3'b110
`define F3_AND     3'b111
`define F3_WORD    3'b010
`define F7_ALT     7'b0100000

`define ALU_ADD 4'd0
`define ALU_SUB 4'd1
`define ALU_SLL 4'd2
`define ALU_SLT 4'd3
`define ALU_XOR 4'd4
`define ALU_SRL 4'd5
`define ALU_OR  4'd6
`define ALU_AND 4'd7
`define ALU_EQ  4'd8

`define SEL_A_REG 1'b0
`define SEL_A_PC  1'b1
`define SEL_B_REG 1'b0
`define SEL_B_IMM 1'b1

`define DEST_NONE 2'd0
`define DEST_ALU  2'd1
`define DEST_MEM  2'd2
`define DEST_PC   2'd3

`define PC_NEXT 1'b0
`define PC_ALU  1'b1

`endif

//--- rv_core_tb.sv
`timescale 1ns/1ps
`default_nettype none

`include "rv_core_settings.svh"

module rv_core_tb
  import rv_core_pkg::*;
();

  localparam word_t val_a         = 32'd100;
  localparam word_t val_b         = 32'hFFFF_FFDB; // -37.
  localparam word_t base_addr     = 32'h0000_0400; // x10 holds it.
  localparam word_t load_addr     = 32'h0000_0300;
  localparam word_t load_val      = 32'hCAFE_0000;
  localparam int    store_timeout = 600;
  localparam int    trap_timeout  = 200;
  localparam int    quiet_cycles  = 50;

  logic  clk;
  logic  rst;
  logic  mem_req;
  logic  mem_we;
  word_t mem_addr;
  word_t mem_wdata;
  logic  mem_ack   = 1'b0;
  word_t mem_rdata = '0;
  logic  trap;

  word_t       mem [1024];
  word_t       prog [$];
  word_t       exp_addr [$];
  word_t       exp_data [$];
  word_t       got_addr [$];
  word_t       got_data [$];
  logic [15:0] lfsr      = 16'd93;
  int          ack_delay = -1;
  logic        req_seen  = 1'b0;
  word_t       addr_seen;

  tb_clock_gen u_clk (
    .clk (clk)
  );

  rv_core uut (
    .clk       (clk),
    .rst       (rst),
    .mem_req   (mem_req),
    .mem_we    (mem_we),
    .mem_addr  (mem_addr),
    .mem_wdata (mem_wdata),
    .mem_ack   (mem_ack),
    .mem_rdata (mem_rdata),
    .trap      (trap)
  );

  task automatic stop_with_failure(input string why);
    $display("%s", why);
    $display("Done: errors found");
    $fatal(1);
  endtask

  task automatic compare_value(input string name, input word_t expected, input word_t actual);
    if (actual !== expected) begin
      stop_with_failure($sformatf("ERR %0t %s expected %h got %h",
                                  $time, name, expected, actual));
    end
  endtask

  function automatic logic [15:0] lfsr_step(input logic [15:0] s);
    return s[0] ? ((s >> 1) ^ 16'hB400) : (s >> 1);
  endfunction

  task automatic draw_delay(output int d);
    logic [1:0] bits;
    for (int i = 0; i < 2; i++) begin
      bits[i] = lfsr[0];
      lfsr    = lfsr_step(lfsr);
    end
    d = 1 + bits; // 1 to 4 cycles.
  endtask

  function automatic word_t r_type(input funct7_t f7, input funct3_t f3, input reg_addr_t rd,
                                   input reg_addr_t rs1, input reg_addr_t rs2);
    return {f7, rs2, rs1, f3, rd, `OP_ALU};
  endfunction

  function automatic word_t i_type(input opcode_t op, input funct3_t f3, input reg_addr_t rd,
                                   input reg_addr_t rs1, input logic [11:0] imm);
    return {imm, rs1, f3, rd, op};
  endfunction

  function automatic word_t s_type(input reg_addr_t rs2, input reg_addr_t rs1,
                                   input logic [11:0] imm);
    return {imm[11:5], rs2, rs1, 3'b010, imm[4:0], `OP_STORE};
  endfunction

  function automatic word_t b_type(input funct3_t f3, input reg_addr_t rs1, input reg_addr_t rs2,
                                   input logic [12:0] imm);
    return {imm[12], imm[10:5], rs2, rs1, f3, imm[4:1], imm[11], `OP_BRANCH};
  endfunction

  function automatic word_t u_type(input opcode_t op, input reg_addr_t rd, input logic [19:0] imm);
    return {imm, rd, op};
  endfunction

  function automatic word_t j_type(input reg_addr_t rd, input logic [20:0] imm);
    return {imm[20], imm[10:1], imm[11], imm[19:12], rd, `OP_JAL};
  endfunction

  // rv32i branch conditions by funct3
  function automatic logic branch_rule(input funct3_t f3, input word_t x, input word_t y);
    case (f3)
      3'b000:  return x == y;
      3'b001:  return x != y;
      3'b100:  return $signed(x) < $signed(y);
      3'b101:  return $signed(x) >= $signed(y);
      3'b110:  return x < y;
      default: return x >= y;
    endcase
  endfunction

  task automatic add_instr(input word_t instr);
    prog.push_back(instr);
  endtask

  task automatic add_store(input reg_addr_t rs2, input logic [11:0] off, input word_t value);
    prog.push_back(s_type(rs2, 10, off));
    exp_addr.push_back(base_addr + off);
    exp_data.push_back(value);
  endtask

  task automatic add_branch(input funct3_t f3, input reg_addr_t rs1, input reg_addr_t rs2);
    word_t       x;
    word_t       y;
    logic [11:0] off;
    x   = (rs1 == 5'd1) ? val_a : val_b;
    y   = (rs2 == 5'd1) ? val_a : val_b;
    off = 12'h100 + 12'(prog.size() * 4);
    add_instr(b_type(f3, rs1, rs2, 13'd8));
    if (branch_rule(f3, x, y)) begin
      add_instr(s_type(1, 10, off)); // jumped over.
    end else begin
      add_store(1, off, val_a);
    end
  endtask

  task automatic build_tables();
    word_t pc_j;
    add_instr(i_type(`OP_ALUI, 3'b000, 10, 0, base_addr[11:0]));
    add_instr(i_type(`OP_ALUI, 3'b000, 1, 0, val_a[11:0]));
    add_instr(i_type(`OP_ALUI, 3'b000, 2, 0, val_b[11:0]));
    add_instr(r_type(7'h00, 3'b000, 3, 1, 2));
    add_store(3, 12'h000, val_a + val_b);
    add_instr(r_type(7'h20, 3'b000, 3, 1, 2));
    add_store(3, 12'h004, val_a - val_b);
    add_instr(i_type(`OP_ALUI, 3'b001, 3, 2, 12'd4));
    add_store(3, 12'h008, val_b << 4);
    add_instr(i_type(`OP_ALUI, 3'b101, 3, 2, 12'h402)); // srai by 2.
    add_store(3, 12'h00C, word_t'($signed(val_b) >>> 2));
    add_instr(r_type(7'h00, 3'b101, 3, 2, 1));
    add_store(3, 12'h010, val_b >> val_a[4:0]);
    add_instr(r_type(7'h00, 3'b010, 3, 2, 1));
    add_store(3, 12'h014, word_t'($signed(val_b) < $signed(val_a)));
    add_instr(r_type(7'h00, 3'b011, 3, 2, 1));
    add_store(3, 12'h018, word_t'(val_b < val_a));
    add_instr(i_type(`OP_ALUI, 3'b100, 3, 1, 12'h055));
    add_store(3, 12'h01C, val_a ^ 32'h55);
    add_instr(r_type(7'h00, 3'b110, 3, 1, 2));
    add_store(3, 12'h020, val_a | val_b);
    add_instr(r_type(7'h00, 3'b111, 3, 1, 2));
    add_store(3, 12'h024, val_a & val_b);
    add_instr(u_type(`OP_LUI, 4, 20'h12345));
    add_store(4, 12'h028, {20'h12345, 12'h000});
    pc_j = word_t'(prog.size() * 4);
    add_instr(u_type(`OP_AUIPC, 5, 20'h00001));
    add_store(5, 12'h02C, pc_j + 32'h1000);
    add_instr(i_type(`OP_LOAD, 3'b010, 6, 0, load_addr[11:0]));
    add_instr(i_type(`OP_ALUI, 3'b000, 6, 6, 12'h0BE));
    add_store(6, 12'h030, load_val + 32'hBE);
    add_branch(3'b000, 1, 1);
    add_branch(3'b000, 1, 2);
    add_branch(3'b001, 1, 2);
    add_branch(3'b001, 2, 2);
    add_branch(3'b100, 2, 1);
    add_branch(3'b100, 1, 2);
    add_branch(3'b101, 1, 2);
    add_branch(3'b101, 2, 1);
    add_branch(3'b110, 1, 2);
    add_branch(3'b110, 2, 1);
    add_branch(3'b111, 2, 1);
    add_branch(3'b111, 1, 2);
    pc_j = word_t'(prog.size() * 4);
    add_instr(j_type(11, 21'd8));
    add_instr(s_type(1, 10, 12'h1F8)); // skipped by jal.
    add_store(11, 12'h034, pc_j + 4);
    pc_j = word_t'(prog.size() * 4);
    add_instr(i_type(`OP_JALR, 3'b000, 13, 0, 12'(pc_j + 9))); // odd target, bit 0 dropped.
    add_instr(s_type(1, 10, 12'h1FC));
    add_store(13, 12'h038, pc_j + 4);
    add_instr(32'hFFFF_FFFF); // opcode 7'h7f is not rv32i.
  endtask

  task automatic load_memory();
    for (int i = 0; i < 1024; i++) begin
      mem[i] = 32'h6B00_0000 ^ word_t'(i * 4);
    end
    for (int i = 0; i < prog.size(); i++) begin
      mem[i] = prog[i];
    end
    mem[load_addr[11:2]] = load_val;
  endtask

  // memory answers the handshake a little after each rising edge
  always @(posedge clk) begin
    #2;
    if (mem_req && !req_seen) begin
      compare_value("mem_ack", 1'b0, mem_ack); // req must rise with ack low.
    end
    if (mem_req && req_seen) begin
      compare_value("mem_addr", addr_seen, mem_addr);
    end
    req_seen  = mem_req;
    addr_seen = mem_addr;
    if (mem_req && !mem_ack) begin
      if (ack_delay < 0) begin
        draw_delay(ack_delay);
      end
      ack_delay--;
      if (ack_delay == 0) begin
        ack_delay = -1;
        mem_ack   = 1'b1;
        if (mem_we) begin
          mem[mem_addr[11:2]] = mem_wdata;
          got_addr.push_back(mem_addr);
          got_data.push_back(mem_wdata);
        end else begin
          mem_rdata = mem[mem_addr[11:2]];
        end
      end
    end else if (!mem_req && mem_ack) begin
      if (ack_delay < 0) begin
        draw_delay(ack_delay);
      end
      ack_delay--;
      if (ack_delay == 0) begin
        ack_delay = -1;
        mem_ack   = 1'b0; // release is late by 1 to 4 cycles too.
      end
    end
  end

  initial begin
    int waited;
    rst = 1'b0;
    build_tables();
    load_memory();
    repeat (16) @(posedge clk);
    #2;
    rst = 1'b1;
    for (int k = 0; k < exp_addr.size(); k++) begin
      waited = 0;
      while (got_addr.size() <= k && waited < store_timeout) begin
        @(negedge clk);
        waited++;
      end
      if (got_addr.size() <= k) begin
        stop_with_failure($sformatf("store number %0d to address %h never arrived",
                                    k, exp_addr[k]));
      end
      compare_value("mem_addr", exp_addr[k], got_addr[k]);
      compare_value("mem_wdata", exp_data[k], got_data[k]);
    end
    waited = 0;
    while (!trap && waited < trap_timeout) begin
      @(negedge clk);
      waited++;
    end
    if (!trap) begin
      stop_with_failure("trap never rose after the illegal opcode");
    end
    for (int c = 0; c < quiet_cycles; c++) begin
      @(negedge clk);
      compare_value("mem_req", 1'b0, mem_req); // halted core stays off the bus.
    end
    compare_value("store count", exp_addr.size(), got_addr.size());
    $display("Done: no errors");
    $finish;
  end

endmodule

`default_nettype wire

//--- tb_clock_gen.sv
`timescale 1ns/1ps
`default_nettype none

module tb_clock_gen (
  output logic clk
);

  initial clk = 1'b0;

  always #50 clk = ~clk; // 100 ns period.

endmodule

`default_nettype wire
